//--- logic/keypadPkg.sv
package keypadPkg;

    // key position on the pad, column * 4 + row
    typedef logic [3:0] keyIndexT;

    typedef logic [3:0] digitT;             // one decimal digit
    typedef logic signed [15:0] calcWordT;  // operand or result, wraps

    typedef enum logic [2:0] {
        opNone,
        opNegate,
        opAdd,
        opSub,
        opMul,
        opClear
    } keyClassT;

    // scan pacing, maximal length so one tick every 31 cycles
    localparam int lfsrWidth = 5;
    typedef logic [lfsrWidth-1:0] lfsrT;
    localparam lfsrT lfsrSeed = 5'b00001;
    localparam lfsrT lfsrTerminal = 5'b10000;  // state just before the seed

    localparam int debounceScans = 3;       // matching full scans to accept
    localparam int debounceWidth = $clog2(debounceScans + 1);

    typedef enum logic [1:0] {
        stScan,
        stCheck,
        stReport,
        stRelease
    } scanStateT;

endpackage

//--- logic/scanTimer.sv
module scanTimer (
    input  logic Clock,
    input  logic Reset,
    input  logic ScanRun,
    output logic ScanTick
);
    import keypadPkg::*;

    lfsrT lfsr;
    logic feedback;

    // taps for x^5 + x^3 + 1
    assign feedback = lfsr[lfsrWidth-1] ^ lfsr[2];

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            lfsr <= lfsrSeed;
        end else if (!ScanRun) begin
            lfsr <= lfsrSeed;                      // hold at seed while idle
        end else begin
            lfsr <= {lfsr[lfsrWidth-2:0], feedback};
        end
    end

    // terminal state is reached 30 steps after the seed
    assign ScanTick = ScanRun && (lfsr == lfsrTerminal);

    // the register never sits on the terminal state for two cycles
    tickIsPulse: assert property (
        @(posedge Clock) disable iff (!Reset)
        ScanTick |=> !ScanTick
    ) else $error("ScanTick high for two cycles");

endmodule

//--- logic/keypadScanner.sv
module keypadScanner (
    input  logic                Clock,
    input  logic                Reset,
    input  logic [3:0]          RowIn,
    output logic [3:0]          ColOut,
    input  logic                ScanTick,
    output logic                ScanRun,
    input  logic                KeyRdy,
    output logic                KeyValid,
    output keypadPkg::keyIndexT KeyIndex
);
    import keypadPkg::*;

    scanStateT state;
    logic [1:0] colIdx;                    // column being driven
    logic secondTick;                      // next tick samples and advances
    logic [15:0] rowBits;                  // one full scan, active low
    logic [debounceWidth-1:0] debCnt;
    logic [4:0] zeroCount;
    keyIndexT zeroIdx;
    logic singleKey;
    logic scanStep;
    logic lastSample;
    logic noKey;

    assign scanStep = ScanTick && (state == stScan || state == stRelease);
    assign lastSample = scanStep && secondTick && (colIdx == 2'd3);
    assign noKey = &{RowIn, rowBits[11:0]};  // last column read live

    // exact one-zero check over the scan
    always_comb begin
        zeroCount = '0;
        zeroIdx = '0;
        for (int i = 0; i < 16; i++) begin
            if (!rowBits[i]) begin
                zeroCount = zeroCount + 5'd1;
                zeroIdx = keyIndexT'(i);
            end
        end
    end

    assign singleKey = (zeroCount == 5'd1);

    always_ff @(posedge Clock) begin
        if (scanStep && secondTick) begin
            rowBits[colIdx*4 +: 4] <= RowIn;
        end
    end

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            state <= stScan;
            colIdx <= 2'd0;
            ColOut <= 4'b1110;             // column 0 low
            secondTick <= 1'b0;
            debCnt <= '0;
            KeyIndex <= '0;
            KeyValid <= 1'b0;
            ScanRun <= 1'b0;
        end else begin
            ScanRun <= !KeyRdy && (state != stReport);
            KeyValid <= 1'b0;
            if (scanStep) begin
                secondTick <= !secondTick;
                if (secondTick) begin
                    colIdx <= colIdx + 2'd1;
                    ColOut <= {ColOut[2:0], ColOut[3]};
                end
            end
            case (state)
                stScan: begin
                    if (lastSample) state <= stCheck;
                end
                stCheck: begin
                    state <= stScan;
                    if (!singleKey) begin
                        debCnt <= '0;              // none, or several keys
                    end else if (debCnt != '0 && zeroIdx == KeyIndex) begin
                        if (debCnt == debounceWidth'(debounceScans - 1)) begin
                            debCnt <= '0;
                            KeyValid <= 1'b1;
                            state <= stReport;
                        end else begin
                            debCnt <= debCnt + 1'b1;
                        end
                    end else begin
                        debCnt <= debounceWidth'(1);  // new candidate
                        KeyIndex <= zeroIdx;
                    end
                end
                stReport: state <= stRelease;
                stRelease: begin
                    // wait for the read and one clean scan
                    if (lastSample && !KeyRdy && noKey) state <= stScan;
                end
                default: state <= stScan;
            endcase
        end
    end

    colOneHot: assert property (
        @(posedge Clock) disable iff (!Reset)
        $onehot(~ColOut)
    ) else $error("ColOut does not drive exactly one column");

    validInReport: assert property (
        @(posedge Clock) disable iff (!Reset)
        KeyValid |-> state == stReport
    ) else $error("KeyValid outside stReport");

endmodule

//--- logic/keyDecoder.sv
module keyDecoder (
    input  logic                Clock,
    input  logic                Reset,
    input  logic                KeyValid,
    input  keypadPkg::keyIndexT KeyIndex,
    input  logic                KeyRd,
    output logic                KeyRdy,
    output keypadPkg::digitT    Number,
    output keypadPkg::keyClassT Operator,
    output logic                EqualSign
);
    import keypadPkg::*;

    digitT digit;
    keyClassT keyClass;
    logic isEqual;

    always_comb begin
        digit = '0;
        keyClass = opNone;
        isEqual = 1'b0;
        case (KeyIndex)
            4'd0:  digit = 4'd1;
            4'd1:  digit = 4'd4;
            4'd2:  digit = 4'd7;
            4'd3:  keyClass = opMul;       // *
            4'd4:  digit = 4'd2;
            4'd5:  digit = 4'd5;
            4'd6:  digit = 4'd8;
            4'd7:  digit = 4'd0;
            4'd8:  digit = 4'd3;
            4'd9:  digit = 4'd6;
            4'd10: digit = 4'd9;
            4'd11: keyClass = opNegate;    // #
            4'd12: keyClass = opAdd;       // A
            4'd13: keyClass = opSub;       // B
            4'd14: isEqual = 1'b1;         // C
            default: keyClass = opClear;   // D
        endcase
    end

    always_ff @(posedge Clock) begin
        if (KeyValid) begin
            Number <= digit;
            Operator <= keyClass;
            EqualSign <= isEqual;
        end
    end

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            KeyRdy <= 1'b0;
        end else if (KeyValid) begin
            KeyRdy <= 1'b1;
        end else if (KeyRd) begin
            KeyRdy <= 1'b0;
        end
    end

    // scanner must hold off until the previous key was read
    noOverrun: assert property (
        @(posedge Clock) disable iff (!Reset)
        KeyValid |-> !KeyRdy
    ) else $error("key arrived before previous one was read");

endmodule

//--- logic/calcCore.sv
module calcCore (
    input  logic                Clock,
    input  logic                Reset,
    input  logic                KeyRdy,
    input  keypadPkg::digitT    Number,
    input  keypadPkg::keyClassT Operator,
    input  logic                EqualSign,
    output logic                KeyRd,
    output keypadPkg::calcWordT Result,
    output logic                ResultValid
);
    import keypadPkg::*;

    calcWordT Entry;
    calcWordT Accumulator;
    calcWordT applied;
    keyClassT PendingOp;
    logic Fresh;                           // next digit starts a new entry

    function automatic calcWordT applyOp(keyClassT op, calcWordT lhs, calcWordT rhs);
        case (op)
            opAdd:   return lhs + rhs;
            opSub:   return lhs - rhs;
            opMul:   return lhs * rhs;     // low 16 bits kept
            default: return rhs;
        endcase
    endfunction

    assign applied = applyOp(PendingOp, Accumulator, Entry);

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            KeyRd <= 1'b0;
            ResultValid <= 1'b0;
            Result <= '0;
            Entry <= '0;
            Accumulator <= '0;
            PendingOp <= opNone;
            Fresh <= 1'b0;
        end else begin
            KeyRd <= KeyRdy && !KeyRd;     // one pulse per key
            ResultValid <= 1'b0;
            if (KeyRd) begin
                if (EqualSign) begin
                    Result <= applied;
                    ResultValid <= 1'b1;
                    Entry <= applied;      // chain from the result
                    Accumulator <= '0;
                    PendingOp <= opNone;
                    Fresh <= 1'b1;
                end else begin
                    case (Operator)
                        opNone: begin
                            if (Fresh) begin
                                Entry <= calcWordT'(Number);
                            end else begin
                                Entry <= Entry * calcWordT'(10) + calcWordT'(Number);
                            end
                            Fresh <= 1'b0;
                        end
                        opNegate: Entry <= -Entry;
                        opAdd, opSub, opMul: begin
                            Accumulator <= applied;
                            Entry <= '0;
                            PendingOp <= Operator;
                            Fresh <= 1'b0;
                        end
                        opClear: begin
                            Result <= '0;
                            Entry <= '0;
                            Accumulator <= '0;
                            PendingOp <= opNone;
                            Fresh <= 1'b0;
                        end
                        default: PendingOp <= PendingOp;
                    endcase
                end
            end
        end
    end

    resultAfterRead: assert property (
        @(posedge Clock) disable iff (!Reset)
        ResultValid |-> $past(KeyRd)
    ) else $error("ResultValid without a key read");

endmodule

//--- logic/keypadCalcTop.sv
module keypadCalcTop (
    input  logic                Clock,
    input  logic                Reset,
    input  logic [3:0]          RowIn,
    output logic [3:0]          ColOut,
    output keypadPkg::calcWordT Result,
    output logic                ResultValid
);
    import keypadPkg::*;

    logic scanRun;
    logic scanTick;
    logic keyValid;
    keyIndexT keyIndex;
    logic keyRdy;
    logic keyRd;
    digitT number;
    keyClassT operator;
    logic equalSign;

    scanTimer timer_i (
        .Clock    (Clock),
        .Reset    (Reset),
        .ScanRun  (scanRun),
        .ScanTick (scanTick)
    );

    keypadScanner scanner_i (
        .Clock    (Clock),
        .Reset    (Reset),
        .RowIn    (RowIn),
        .ColOut   (ColOut),
        .ScanTick (scanTick),
        .ScanRun  (scanRun),
        .KeyRdy   (keyRdy),          // back-pressure
        .KeyValid (keyValid),
        .KeyIndex (keyIndex)
    );

    keyDecoder decoder_i (
        .Clock     (Clock),
        .Reset     (Reset),
        .KeyValid  (keyValid),
        .KeyIndex  (keyIndex),
        .KeyRd     (keyRd),
        .KeyRdy    (keyRdy),
        .Number    (number),
        .Operator  (operator),
        .EqualSign (equalSign)
    );

    calcCore core_i (
        .Clock       (Clock),
        .Reset       (Reset),
        .KeyRdy      (keyRdy),
        .Number      (number),
        .Operator    (operator),
        .EqualSign   (equalSign),
        .KeyRd       (keyRd),
        .Result      (Result),
        .ResultValid (ResultValid)
    );

endmodule

//--- verif/keypadTasks.svh
// columns step 0 to 3 and back to 0 with no result pulse
task automatic idleScanTest();
    logic [3:0] prev;
    logic [3:0] expCol;
    int col;
    prev = ColOut;
    col = 0;
    checkValue("ColOut", 4'b1110, ColOut);  // column 0 after reset
    while (col < 4) begin
        @(negedge Clock);
        if (ColOut != prev) begin
            col++;
            expCol = ~(4'b0001 << (col % 4));  // only the next column low
            checkValue("ColOut", expCol, ColOut);
            prev = ColOut;
        end
    end
    checkValue("ResultValid pulses", 0, pulseCount);
    finishTest("idle scan");
endtask

task automatic addTest();
    enterNumber(randomOperand());
    enterKey("A");
    enterNumber(randomOperand());
    enterKey("C");
    expectResult();
    finishTest("add");
endtask

task automatic subMulNegTest();
    enterNumber(randomOperand());
    enterKey("B");
    enterNumber(randomOperand());
    enterKey("C");
    expectResult();
    enterNumber(randomOperand());
    enterKey("*");
    enterNumber(randomOperand());  // product wraps at 16 bits
    enterKey("C");
    expectResult();
    enterNumber(randomOperand());
    enterKey("#");
    enterKey("B");
    enterNumber(randomOperand());
    enterKey("C");
    expectResult();
    finishTest("subtract, multiply, negate");
endtask

task automatic chainClearTest();
    enterKey("A");                 // continues from last result
    enterNumber(randomOperand());
    enterKey("C");
    expectResult();
    enterKey("D");
    enterKey("C");
    expectResult();
    finishTest("chain and clear");
endtask

task automatic rejectTest();
    enterKey("D");
    enterKey("5");
    holdKeys((16'b1 << keyPos("1")) | (16'b1 << keyPos("9")), 4);  // two keys
    holdKeys(16'b1 << keyPos("3"), 2);   // shorter than debounce
    enterKey("A");
    enterKey("7");
    enterKey("C");
    expectResult();
    finishTest("reject");
endtask

task automatic holdTest();
    enterKey("D");
    holdKeys(16'b1 << keyPos("4"), 12);
    modelKey("4");                 // long hold still one digit
    enterKey("A");
    enterKey("2");
    enterKey("C");
    expectResult();
    finishTest("long hold");
endtask

//--- verif/keypadCalcTb.sv
module keypadCalcTb;
    import keypadPkg::*;

    localparam int scanCycles = 8 * ((1 << lfsrWidth) - 1);  // one full scan
    localparam int maxCycles = 150000;     // about 50 presses under 1800 cycles, plus margin

    logic Clock = 1'b0;
    logic Reset;
    logic [3:0] RowIn;
    logic [3:0] ColOut;
    calcWordT Result;
    logic ResultValid;

    logic [15:0] pressed;                  // keys held down, by index
    string keyLayout = "147*2580369#ABCD"; // key at each pad index
    int cycleCount = 0;
    int errors = 0;
    int checks = 0;
    int testsRun = 0;
    int testErrors = 0;                    // errors before the current test
    int pulseCount = 0;                    // ResultValid pulses seen
    int lastResult = 0;
    int seed = 32;

    // expected calculator state
    logic signed [15:0] mEntry = '0;
    logic signed [15:0] mAcc = '0;
    logic signed [15:0] mResult = '0;
    byte mOp = 0;                          // pending operator key, 0 for none
    logic mFresh = 1'b0;
    int mPulses = 0;

    keypadCalcTop dut_i (
        .Clock       (Clock),
        .Reset       (Reset),
        .RowIn       (RowIn),
        .ColOut      (ColOut),
        .Result      (Result),
        .ResultValid (ResultValid)
    );

    always #4 Clock = ~Clock;

    // wired AND, a pressed key pulls its row to its column level
    always_comb begin
        RowIn = 4'b1111;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                if (pressed[c*4 + r] && !ColOut[c]) RowIn[r] = 1'b0;
            end
        end
    end

    always @(negedge Clock) begin
        if (ResultValid) begin
            pulseCount++;
            lastResult = int'(Result);
        end
    end

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount == maxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", maxCycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic checkValue(string name, int expected, int actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic finishTest(string name);
        testsRun++;
        if (errors == testErrors) $display("test %s: ok", name);
        else $display("test %s: %0d error(s)", name, errors - testErrors);
        testErrors = errors;
    endtask

    function automatic int keyPos(byte k);
        for (int i = 0; i < 16; i++) begin
            if (keyLayout[i] == k) return i;
        end
        return 0;
    endfunction

    function automatic logic signed [15:0] pendingResult();
        case (mOp)
            "A": return mAcc + mEntry;
            "B": return mAcc - mEntry;
            "*": return mAcc * mEntry;     // low 16 bits
            default: return mEntry;
        endcase
    endfunction

    // apply one accepted key to the expected state
    task automatic modelKey(byte k);
        case (k)
            "#": mEntry = -mEntry;
            "A", "B", "*": begin
                mAcc = pendingResult();
                mEntry = '0;
                mOp = k;
                mFresh = 1'b0;
            end
            "C": begin
                mResult = pendingResult();
                mPulses++;
                mEntry = mResult;
                mAcc = '0;
                mOp = 0;
                mFresh = 1'b1;
            end
            "D": begin
                mEntry = '0;
                mAcc = '0;
                mResult = '0;
                mOp = 0;
                mFresh = 1'b0;
            end
            default: begin
                mEntry = mFresh ? 16'(k - "0") : mEntry * 10 + (k - "0");
                mFresh = 1'b0;
            end
        endcase
    endtask

    // press from the start of a scan, hold, then release for two scans
    task automatic holdKeys(logic [15:0] keys, int scans);
        @(negedge Clock);
        while (ColOut == 4'b1110) @(negedge Clock);
        while (ColOut != 4'b1110) @(negedge Clock);
        pressed = keys;
        repeat (scans * scanCycles) @(negedge Clock);
        pressed = '0;
        repeat (2 * scanCycles) @(negedge Clock);
    endtask

    task automatic enterKey(byte k);
        holdKeys(16'b1 << keyPos(k), 4);
        modelKey(k);
    endtask

    task automatic enterNumber(int value);
        string digits;
        digits = $sformatf("%0d", value);
        for (int i = 0; i < digits.len(); i++) enterKey(digits[i]);
    endtask

    function automatic int randomOperand();
        return 100 + ($unsigned($random(seed)) % 900);  // three digits
    endfunction

    task automatic expectResult();
        while (pulseCount < mPulses) @(negedge Clock);
        checkValue("ResultValid pulses", mPulses, pulseCount);
        checkValue("Result", mResult, lastResult);
    endtask

    `include "keypadTasks.svh"

    initial begin
        Reset = 1'b0;
        pressed = '0;
        repeat (3) @(negedge Clock);
        Reset = 1'b1;
        idleScanTest();
        addTest();
        subMulNegTest();
        chainClearTest();
        rejectTest();
        holdTest();
        $display("tests run: %0d, checks: %0d, errors: %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+verif
logic/keypadPkg.sv
logic/scanTimer.sv
logic/keypadScanner.sv
logic/keyDecoder.sv
logic/calcCore.sv
logic/keypadCalcTop.sv
verif/keypadCalcTb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module keypadCalcTb -Mdir obj_dir
	./obj_dir/VkeypadCalcTb | awk '{ print } /^Result: PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
